//--- Makefile
TOP = soc_bus_tb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f soc_bus.f --top-module soc_bus
	verilator --lint-only --timing --timescale 1ns/1ps -f soc_bus.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f soc_bus.f \
		--top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -qx "Test OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- rtl/soc_bus.sv
`default_nettype none

`include "soc_bus_defines.svh"

module soc_bus import soc_bus_pkg::*; (
  input  logic                                                  clk_i,
  input  logic                                                  rst_n,
  input  logic [`SOC_N_CLUSTERS-1:0]                            cl_req_valid,
  output logic [`SOC_N_CLUSTERS-1:0]                            cl_req_ready,
  input  logic [`SOC_N_CLUSTERS-1:0][`SOC_AW-1:0]               cl_req_addr,
  input  logic [`SOC_N_CLUSTERS-1:0]                            cl_req_write,
  input  logic [`SOC_N_CLUSTERS-1:0][`SOC_DW-1:0]               cl_req_wdata,
  input  logic [`SOC_N_CLUSTERS-1:0][`SOC_IW_INP-1:0]           cl_req_id,
  output logic [`SOC_N_CLUSTERS-1:0]                            cl_rsp_valid,
  input  logic [`SOC_N_CLUSTERS-1:0]                            cl_rsp_ready,
  output logic [`SOC_N_CLUSTERS-1:0][`SOC_DW-1:0]               cl_rsp_rdata,
  output logic [`SOC_N_CLUSTERS-1:0]                            cl_rsp_err,
  output logic [`SOC_N_CLUSTERS-1:0][`SOC_IW_INP-1:0]           cl_rsp_id,
  output logic [`SOC_N_TARGETS-2:0]                             tgt_req_valid,
  input  logic [`SOC_N_TARGETS-2:0]                             tgt_req_ready,
  output logic [`SOC_N_TARGETS-2:0][`SOC_AW-1:0]                tgt_req_addr,
  output logic [`SOC_N_TARGETS-2:0]                             tgt_req_write,
  output logic [`SOC_N_TARGETS-2:0][`SOC_DW-1:0]                tgt_req_wdata,
  output logic [`SOC_N_TARGETS-2:0][`SOC_IW_OUP-1:0]            tgt_req_id,
  input  logic [`SOC_N_TARGETS-2:0]                             tgt_rsp_valid,
  output logic [`SOC_N_TARGETS-2:0]                             tgt_rsp_ready,
  input  logic [`SOC_N_TARGETS-2:0][`SOC_DW-1:0]                tgt_rsp_rdata,
  input  logic [`SOC_N_TARGETS-2:0]                             tgt_rsp_err,
  input  logic [`SOC_N_TARGETS-2:0][`SOC_IW_OUP-1:0]            tgt_rsp_id
);

  localparam int unsigned NC = `SOC_N_CLUSTERS;
  localparam int unsigned NT = `SOC_N_TARGETS;
  localparam int unsigned D  = `SOC_SLICE_DEPTH;

  // Demux side indexed [cluster][target], arbiter side [target][cluster]
  logic     [NC-1:0][NT-1:0] dmx_req_valid, dmx_req_ready, dmx_rsp_valid, dmx_rsp_ready;
  soc_req_t [NC-1:0]         dmx_req;
  logic     [NT-1:0][NC-1:0] arb_req_valid, arb_req_ready, arb_rsp_valid, arb_rsp_ready;
  soc_rsp_t [NT-1:0]         arb_rsp;

  for (genvar c = 0; c < NC; c++) begin : gen_cl
    for (genvar t = 0; t < NT; t++) begin : gen_xpose
      assign arb_req_valid[t][c] = dmx_req_valid[c][t];
      assign dmx_req_ready[c][t] = arb_req_ready[t][c];
      assign dmx_rsp_valid[c][t] = arb_rsp_valid[t][c];
      assign arb_rsp_ready[t][c] = dmx_rsp_ready[c][t];
    end

    soc_bus_demux i_demux (
      .clk_i, .rst_n,
      .cl_req_valid  (cl_req_valid[c]),  .cl_req_ready (cl_req_ready[c]),
      .cl_req_addr   (cl_req_addr[c]),   .cl_req_write (cl_req_write[c]),
      .cl_req_wdata  (cl_req_wdata[c]),  .cl_req_id    (cl_req_id[c]),
      .cl_rsp_valid  (cl_rsp_valid[c]),  .cl_rsp_ready (cl_rsp_ready[c]),
      .cl_rsp_rdata  (cl_rsp_rdata[c]),  .cl_rsp_err   (cl_rsp_err[c]),
      .cl_rsp_id     (cl_rsp_id[c]),
      .tgt_req_valid (dmx_req_valid[c]), .tgt_req      (dmx_req[c]),
      .tgt_req_ready (dmx_req_ready[c]), .tgt_rsp_valid (dmx_rsp_valid[c]),
      .tgt_rsp       (arb_rsp),          .tgt_rsp_ready (dmx_rsp_ready[c])
    );
  end

  for (genvar t = 0; t < NT; t++) begin : gen_tgt
    // Stage 0 faces the arbiter on requests and the target on responses
    logic     [D:0] rq_valid, rq_ready, rs_valid, rs_ready;
    soc_req_t [D:0] rq_data;
    soc_rsp_t [D:0] rs_data;

    soc_bus_arbiter i_arbiter (
      .clk_i, .rst_n,
      .req_valid     (arb_req_valid[t]), .req           (dmx_req),
      .req_ready     (arb_req_ready[t]),
      .tgt_req_valid (rq_valid[0]),      .tgt_req       (rq_data[0]),
      .tgt_req_ready (rq_ready[0]),
      .tgt_rsp_valid (rs_valid[D]),      .tgt_rsp       (rs_data[D]),
      .tgt_rsp_ready (rs_ready[D]),
      .rsp_valid     (arb_rsp_valid[t]), .rsp           (arb_rsp[t]),
      .rsp_ready     (arb_rsp_ready[t])
    );

    for (genvar s = 0; s < D; s++) begin : gen_slice
      soc_bus_slice #(.payload_t(soc_req_t)) i_req_slice (
        .clk_i, .rst_n,
        .in_valid  (rq_valid[s]),   .in_ready  (rq_ready[s]),   .in_data  (rq_data[s]),
        .out_valid (rq_valid[s+1]), .out_ready (rq_ready[s+1]), .out_data (rq_data[s+1])
      );
      soc_bus_slice #(.payload_t(soc_rsp_t)) i_rsp_slice (
        .clk_i, .rst_n,
        .in_valid  (rs_valid[s]),   .in_ready  (rs_ready[s]),   .in_data  (rs_data[s]),
        .out_valid (rs_valid[s+1]), .out_ready (rs_ready[s+1]), .out_data (rs_data[s+1])
      );
    end

    if (t == IDX_PERIPH) begin : gen_periph
      soc_periph_regs i_periph (
        .clk_i, .rst_n,
        .req_valid (rq_valid[D]), .req_ready (rq_ready[D]), .req (rq_data[D]),
        .rsp_valid (rs_valid[0]), .rsp_ready (rs_ready[0]), .rsp (rs_data[0])
      );
    end else begin : gen_ext
      assign tgt_req_valid[t] = rq_valid[D];
      assign rq_ready[D]      = tgt_req_ready[t];
      assign tgt_req_addr[t]  = rq_data[D].addr;
      assign tgt_req_write[t] = rq_data[D].write;
      assign tgt_req_wdata[t] = rq_data[D].wdata;
      assign tgt_req_id[t]    = rq_data[D].id;
      assign rs_valid[0]      = tgt_rsp_valid[t];
      assign tgt_rsp_ready[t] = rs_ready[0];
      assign rs_data[0]       = '{rdata: tgt_rsp_rdata[t], err: tgt_rsp_err[t],
                                  id: tgt_rsp_id[t]};
    end
  end

endmodule

`default_nettype wire

//--- rtl/soc_bus_arbiter.sv
`default_nettype none

`include "soc_bus_defines.svh"

module soc_bus_arbiter import soc_bus_pkg::*; (
  input  logic                             clk_i,
  input  logic                             rst_n,
  input  logic [`SOC_N_CLUSTERS-1:0]       req_valid,
  input  soc_req_t [`SOC_N_CLUSTERS-1:0]   req,
  output logic [`SOC_N_CLUSTERS-1:0]       req_ready,
  output logic                             tgt_req_valid,
  output soc_req_t                         tgt_req,
  input  logic                             tgt_req_ready,
  input  logic                             tgt_rsp_valid,
  input  soc_rsp_t                         tgt_rsp,
  output logic                             tgt_rsp_ready,
  output logic [`SOC_N_CLUSTERS-1:0]       rsp_valid,
  output soc_rsp_t                         rsp,
  input  logic [`SOC_N_CLUSTERS-1:0]       rsp_ready
);

  localparam int unsigned NC = `SOC_N_CLUSTERS;
  localparam int unsigned CW = `SOC_IW_OUP - `SOC_IW_INP;

  typedef logic [CW-1:0] cl_idx_t;

  cl_idx_t       ptr_q, lock_idx_q, win, rsp_idx;
  logic          lock_q, found;
  logic [NC-1:0] grant;

  always_comb begin
    grant = '0;
    win   = ptr_q;
    found = 1'b0;
    if (lock_q) begin
      // Hold a stalled grant so the payload stays put
      win        = lock_idx_q;
      found      = req_valid[lock_idx_q];
      grant[win] = found;
    end else begin
      for (int k = 0; k < NC; k++) begin
        if (!found && req_valid[(int'(ptr_q) + k) % NC]) begin
          found      = 1'b1;
          win        = cl_idx_t'((int'(ptr_q) + k) % NC);
          grant[win] = 1'b1;
        end
      end
    end
  end

  assign tgt_req_valid = found;
  assign req_ready     = tgt_req_ready ? grant : '0;

  always_comb begin
    tgt_req    = req[win];
    tgt_req.id = {win, req[win].id[`SOC_IW_INP-1:0]};  // Tag with requester index
  end

  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      ptr_q      <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      lock_q     <= found && !tgt_req_ready;
      lock_idx_q <= win;
      if (found && tgt_req_ready) ptr_q <= cl_idx_t'((int'(win) + 1) % NC);
    end
  end

  // Response return by id
  assign rsp_idx = tgt_rsp.id[`SOC_IW_OUP-1:`SOC_IW_INP];

  always_comb begin
    rsp = tgt_rsp;
    rsp.id[`SOC_IW_OUP-1:`SOC_IW_INP] = '0;  // Cluster sees its own id again
  end

  assign rsp_valid     = tgt_rsp_valid ? NC'(1) << rsp_idx : '0;
  assign tgt_rsp_ready = rsp_ready[rsp_idx];

  // Relies on the demux keeping its request valid until taken
  assert property (@(posedge clk_i) disable iff (!rst_n)
    tgt_req_valid && !tgt_req_ready |=> tgt_req_valid && $stable(tgt_req))
    else $error("target request dropped or changed while stalled");

endmodule

`default_nettype wire

//--- rtl/soc_bus_defines.svh
`ifndef SOC_BUS_DEFINES_SVH
`define SOC_BUS_DEFINES_SVH

// Requesters and memory ports
`define SOC_N_CLUSTERS   2
`define SOC_L2_N_PORTS   2
`define SOC_N_TARGETS    (`SOC_N_CLUSTERS + `SOC_L2_N_PORTS + 1)  // Clusters, L2, periph

// Bus widths
`define SOC_AW           32
`define SOC_DW           32
`define SOC_IW_INP       4
`define SOC_IW_OUP       (`SOC_IW_INP + 1)  // One extra bit for the cluster index

`define SOC_SLICE_DEPTH  1

// Cluster windows
`define SOC_CL_BASE      32'h1000_0000
`define SOC_CL_STRIDE    32'h0040_0000
`define SOC_CL_SIZE      32'h0030_0000

// L2 ports, 64 KiB each
`define SOC_L2_BASE      32'h1C00_0000
`define SOC_L2_SIZE      32'h0001_0000

`define SOC_PERIPH_BASE  32'h1A10_0000
`define SOC_PERIPH_SIZE  32'h0000_0020

`endif

//--- rtl/soc_bus_demux.sv
`default_nettype none

`include "soc_bus_defines.svh"

module soc_bus_demux import soc_bus_pkg::*; (
  input  logic                            clk_i,
  input  logic                            rst_n,
  input  logic                            cl_req_valid,
  output logic                            cl_req_ready,
  input  logic [`SOC_AW-1:0]              cl_req_addr,
  input  logic                            cl_req_write,
  input  logic [`SOC_DW-1:0]              cl_req_wdata,
  input  logic [`SOC_IW_INP-1:0]          cl_req_id,
  output logic                            cl_rsp_valid,
  input  logic                            cl_rsp_ready,
  output logic [`SOC_DW-1:0]              cl_rsp_rdata,
  output logic                            cl_rsp_err,
  output logic [`SOC_IW_INP-1:0]          cl_rsp_id,
  output logic [`SOC_N_TARGETS-1:0]       tgt_req_valid,
  output soc_req_t                        tgt_req,
  input  logic [`SOC_N_TARGETS-1:0]       tgt_req_ready,
  input  logic [`SOC_N_TARGETS-1:0]       tgt_rsp_valid,
  input  soc_rsp_t [`SOC_N_TARGETS-1:0]   tgt_rsp,
  output logic [`SOC_N_TARGETS-1:0]       tgt_rsp_ready
);

  localparam int unsigned N_TGT   = `SOC_N_TARGETS;
  localparam int unsigned IW_OUP  = `SOC_IW_OUP;
  localparam logic [2:0]  MAX_OUT = 3'd7;

  soc_tgt_idx_t           sel, cur_tgt_q;
  logic                   hit, en_q, route_ok;
  logic                   issue, err_accept, rsp_sel_valid, rsp_fire;
  logic [2:0]             cnt_q;                // Outstanding toward cur_tgt_q
  logic                   err_valid_q;
  logic [`SOC_IW_INP-1:0] err_id_q;
  logic [N_TGT-1:0]       cur_onehot;

  function automatic logic in_window(input logic [`SOC_AW-1:0] addr, base, size);
    return (addr >= base) && ((addr - base) < size);
  endfunction

  // Address map
  always_comb begin
    hit = 1'b0;
    sel = '0;
    for (int i = 0; i < `SOC_N_CLUSTERS; i++) begin
      if (in_window(cl_req_addr, `SOC_CL_BASE + i * `SOC_CL_STRIDE, `SOC_CL_SIZE)) begin
        hit = 1'b1;
        sel = soc_tgt_idx_t'(i);
      end
    end
    for (int i = 0; i < `SOC_L2_N_PORTS; i++) begin
      if (in_window(cl_req_addr, `SOC_L2_BASE + i * `SOC_L2_SIZE, `SOC_L2_SIZE)) begin
        hit = 1'b1;
        sel = soc_tgt_idx_t'(IDX_L2_MEM + i);
      end
    end
    if (in_window(cl_req_addr, `SOC_PERIPH_BASE, `SOC_PERIPH_SIZE)) begin
      hit = 1'b1;
      sel = IDX_PERIPH;
    end
  end

  // Switching targets or erroring needs an empty pipe
  assign route_ok      = en_q && !err_valid_q &&
                         (cnt_q == '0 || (hit && sel == cur_tgt_q && cnt_q != MAX_OUT));
  assign tgt_req_valid = (cl_req_valid && hit && route_ok) ? N_TGT'(1) << sel : '0;
  assign cl_req_ready  = route_ok && (hit ? tgt_req_ready[sel] : 1'b1);
  assign issue         = cl_req_valid && cl_req_ready && hit;
  assign err_accept    = cl_req_valid && cl_req_ready && !hit;

  assign tgt_req = '{addr: cl_req_addr, write: cl_req_write, wdata: cl_req_wdata,
                     id: IW_OUP'(cl_req_id)};

  assign cur_onehot    = N_TGT'(1) << cur_tgt_q;
  assign rsp_sel_valid = (cnt_q != '0) && |(tgt_rsp_valid & cur_onehot);
  assign rsp_fire      = rsp_sel_valid && cl_rsp_ready;
  assign tgt_rsp_ready = (cl_rsp_ready && cnt_q != '0) ? cur_onehot : '0;

  assign cl_rsp_valid = err_valid_q || rsp_sel_valid;
  assign cl_rsp_err   = err_valid_q || tgt_rsp[cur_tgt_q].err;
  assign cl_rsp_rdata = err_valid_q ? '0 : tgt_rsp[cur_tgt_q].rdata;
  assign cl_rsp_id    = err_valid_q ? err_id_q : tgt_rsp[cur_tgt_q].id[`SOC_IW_INP-1:0];

  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      en_q        <= 1'b0;
      cnt_q       <= '0;
      cur_tgt_q   <= '0;
      err_valid_q <= 1'b0;
    end else begin
      en_q  <= 1'b1;
      cnt_q <= cnt_q + 3'(issue) - 3'(rsp_fire);
      if (issue) cur_tgt_q <= sel;
      if (err_accept) err_valid_q <= 1'b1;
      else if (cl_rsp_ready) err_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (err_accept) err_id_q <= cl_req_id;
  end

  // Arbiters route by id, so only the current target may answer
  assert property (@(posedge clk_i) disable iff (!rst_n)
    |tgt_rsp_valid |-> cnt_q != '0 && (tgt_rsp_valid & ~cur_onehot) == '0)
    else $error("response from a target other than the current one");

endmodule

`default_nettype wire

//--- rtl/soc_bus_pkg.sv
`default_nettype none

`include "soc_bus_defines.svh"

package soc_bus_pkg;

  // Index into the target list
  typedef logic [$clog2(`SOC_N_TARGETS)-1:0] soc_tgt_idx_t;

  // Clusters occupy the low indices
  localparam soc_tgt_idx_t IDX_L2_MEM = soc_tgt_idx_t'(`SOC_N_CLUSTERS);
  localparam soc_tgt_idx_t IDX_PERIPH = soc_tgt_idx_t'(`SOC_N_CLUSTERS + `SOC_L2_N_PORTS);

  // One request word
  typedef struct packed {
    logic [`SOC_AW-1:0]     addr;
    logic                   write;
    logic [`SOC_DW-1:0]     wdata;
    logic [`SOC_IW_OUP-1:0] id;     // Top bit holds the cluster index at a target
  } soc_req_t;

  // One response word
  typedef struct packed {
    logic [`SOC_DW-1:0]     rdata;
    logic                   err;
    logic [`SOC_IW_OUP-1:0] id;
  } soc_rsp_t;

endpackage

`default_nettype wire

//--- rtl/soc_bus_slice.sv
`default_nettype none

module soc_bus_slice #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  logic     main_valid_q, main_valid_d;
  logic     skid_valid_q, skid_valid_d;
  logic     in_ready_q;
  logic     main_load, skid_load;
  payload_t main_data_q, skid_data_q;

  assign in_ready  = in_ready_q;
  assign out_valid = main_valid_q;
  assign out_data  = main_data_q;

  always_comb begin
    main_valid_d = main_valid_q;
    skid_valid_d = skid_valid_q;
    main_load    = 1'b0;
    skid_load    = 1'b0;
    if (main_valid_q && !out_ready) begin
      skid_load    = in_valid && in_ready_q;  // Park item behind stalled output
      skid_valid_d = skid_valid_q || skid_load;
    end else if (skid_valid_q) begin
      // Skid entry moves up while upstream is held off
      main_load    = 1'b1;
      main_valid_d = 1'b1;
      skid_valid_d = 1'b0;
    end else begin
      main_load    = in_valid && in_ready_q;
      main_valid_d = main_load;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      main_valid_q <= 1'b0;
      skid_valid_q <= 1'b0;
      in_ready_q   <= 1'b0;
    end else begin
      main_valid_q <= main_valid_d;
      skid_valid_q <= skid_valid_d;
      in_ready_q   <= !skid_valid_d;  // Ready while the skid entry is free
    end
  end

  always_ff @(posedge clk_i) begin
    if (main_load) main_data_q <= skid_valid_q ? skid_data_q : in_data;
    if (skid_load) skid_data_q <= in_data;
  end

  // Upstream has to hold its item until it is taken
  assert property (@(posedge clk_i) disable iff (!rst_n)
    in_valid && !in_ready |=> in_valid && $stable(in_data))
    else $error("slice input dropped or changed while stalled");

endmodule

`default_nettype wire

//--- rtl/soc_periph_regs.sv
`default_nettype none

`include "soc_bus_defines.svh"

module soc_periph_regs import soc_bus_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n,
  input  logic     req_valid,
  output logic     req_ready,
  input  soc_req_t req,
  output logic     rsp_valid,
  input  logic     rsp_ready,
  output soc_rsp_t rsp
);

  logic [7:0][`SOC_DW-1:0] regs_q;
  logic [2:0]              reg_idx;
  logic                    req_fire;
  logic                    rsp_valid_q;
  soc_rsp_t                rsp_q;

  assign reg_idx   = req.addr[4:2];  // Word select
  assign req_ready = !rsp_valid_q || rsp_ready;
  assign req_fire  = req_valid && req_ready;
  assign rsp_valid = rsp_valid_q;
  assign rsp       = rsp_q;

  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      regs_q      <= '0;
      rsp_valid_q <= 1'b0;
    end else begin
      if (req_fire) rsp_valid_q <= 1'b1;
      else if (rsp_ready) rsp_valid_q <= 1'b0;
      if (req_fire && req.write) regs_q[reg_idx] <= req.wdata;
    end
  end

  // Response word, writes read back as zero
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      rsp_q.rdata <= req.write ? '0 : regs_q[reg_idx];
      rsp_q.err   <= 1'b0;
      rsp_q.id    <= req.id;
    end
  end

endmodule

`default_nettype wire

//--- soc_bus.f
+incdir+rtl
rtl/soc_bus_pkg.sv
rtl/soc_bus_slice.sv
rtl/soc_bus_demux.sv
rtl/soc_bus_arbiter.sv
rtl/soc_periph_regs.sv
rtl/soc_bus.sv
tb/tb_clock_gen.sv
tb/soc_bus_tb.sv

//--- tb/soc_bus_tb.sv
`default_nettype none

module soc_bus_tb;
  timeunit 1ns;
  timeprecision 100ps;

  // Window bases: cluster 0, cluster 1, L2 port 0, L2 port 1, periph, a hole in the map
  localparam logic [31:0] WIN_BASE [6] = '{32'h1000_0000, 32'h1040_0000, 32'h1C00_0000,
                                           32'h1C01_0000, 32'h1A10_0000, 32'h1030_0000};

  logic             clk, rst_n;
  logic [1:0]       cl_req_valid, cl_req_ready, cl_req_write;
  logic [1:0]       cl_rsp_valid, cl_rsp_ready, cl_rsp_err;
  logic [1:0][31:0] cl_req_addr, cl_req_wdata, cl_rsp_rdata;
  logic [1:0][3:0]  cl_req_id, cl_rsp_id;
  logic [3:0]       tgt_req_valid, tgt_req_ready, tgt_req_write;
  logic [3:0]       tgt_rsp_valid, tgt_rsp_ready, tgt_rsp_err;
  logic [3:0][31:0] tgt_req_addr, tgt_req_wdata, tgt_rsp_rdata;
  logic [3:0][4:0]  tgt_req_id, tgt_rsp_id;

  integer      seed = 20479;
  int          value_errs = 0;
  int          other_errs = 0;
  int          cyc = 0;
  bit          always_rdy, rsp_rand;
  logic [31:0] ref_mem [logic [31:0]];  // Expected contents seen by the clusters
  logic [31:0] tgt_mem [logic [31:0]];  // Storage of the target models
  logic [36:0] exp_q [2][$];            // {rdata, err, id} per cluster
  logic [71:0] sent_q [2][$];           // {target, addr, write, wdata, id}
  logic [37:0] trsp_q [4][$];           // Pending target responses
  int          due_q [4][$];
  logic [3:0]  lat_pend;
  logic [4:0]  lat_id [4];

  tb_clock_gen clock_gen_inst (.clk(clk), .rst_n(rst_n));

  soc_bus soc_bus_inst (.clk_i(clk), .*);

  function automatic int target_of(input logic [31:0] a);
    if (a >= 32'h1000_0000 && a < 32'h1030_0000) return 0;
    if (a >= 32'h1040_0000 && a < 32'h1070_0000) return 1;
    if (a >= 32'h1C00_0000 && a < 32'h1C01_0000) return 2;
    if (a >= 32'h1C01_0000 && a < 32'h1C02_0000) return 3;
    if (a >= 32'h1A10_0000 && a < 32'h1A10_0020) return 4;
    return -1;  // Unmapped
  endfunction

  // Contents of a target word that was never written
  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return {a[15:0], a[31:16]} ^ 32'h5A5A_A5A5;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    assert (got === exp) else begin
      value_errs++;
      $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic send_request(input int c, input logic [31:0] addr, input logic wr,
                              input logic [31:0] wd);
    logic [3:0]  id;
    logic [36:0] exp;
    int          t;
    int          waited;
    id = 4'($random(seed));
    cl_req_valid[c] = 1'b1;
    cl_req_addr[c]  = addr;
    cl_req_write[c] = wr;
    cl_req_wdata[c] = wd;
    cl_req_id[c]    = id;
    waited = 0;
    @(negedge clk);
    while (!cl_req_ready[c] && waited < 1000) begin
      @(negedge clk);
      waited++;
    end
    assert (cl_req_ready[c]) else begin
      other_errs++;
      $display("Cluster %0d request to %h was never accepted", c, addr);
    end
    if (cl_req_ready[c]) begin
      t = target_of(addr);
      if (t < 0) begin
        exp = {32'h0, 1'b1, id};
      end else if (wr) begin
        ref_mem[addr] = wd;
        exp = {32'h0, 1'b0, id};
      end else if (ref_mem.exists(addr)) begin
        exp = {ref_mem[addr], 1'b0, id};
      end else begin
        exp = {(t == 4) ? 32'h0 : fill_word(addr), 1'b0, id};  // Periph resets to zero
      end
      if (t >= 0 && t < 4) sent_q[c].push_back({3'(t), addr, wr, wd, id});
      exp_q[c].push_back(exp);
    end
    @(posedge clk);
    #2;
    cl_req_valid[c] = 1'b0;
  endtask

  // Mode 0 mixed traffic after periph reads, mode 1 L2 port 0 only, mode 2 mixed
  task automatic run_cluster(input int c, input int mode, input int n);
    logic [31:0] addr;
    logic [31:0] off;
    int          kind;
    int          gap;
    if (mode == 0) begin
      for (int i = 0; i < 4; i++) send_request(c, WIN_BASE[4] + 32'(c * 16 + i * 4), 1'b0, '0);
    end
    for (int i = 0; i < n; i++) begin
      kind = (mode == 1) ? 2 : int'($unsigned($random(seed)) % 6);
      off  = 32'(c * 16) + 32'(($unsigned($random(seed)) % 4) * 4);  // Bit 4 picks the cluster
      addr = WIN_BASE[kind] + off;
      if (kind == 5 && $random(seed) % 2 == 0) addr = off;  // Bottom of the map
      send_request(c, addr, 1'($random(seed)), $random(seed));
      gap = int'($unsigned($random(seed)) % 3);
      repeat (gap) begin
        @(posedge clk);
        #2;
      end
    end
  endtask

  task automatic drain_responses();
    int waited;
    waited = 0;
    while (exp_q[0].size() + exp_q[1].size() > 0 && waited < 2000) begin
      @(posedge clk);
      waited++;
    end
    assert (exp_q[0].size() + exp_q[1].size() == 0) else begin
      other_errs++;
      $display("Timed out with %0d responses missing", exp_q[0].size() + exp_q[1].size());
    end
    assert (sent_q[0].size() + sent_q[1].size() == 0) else begin
      other_errs++;
      $display("Some requests never reached their target");
    end
    @(posedge clk);
    #2;
  endtask

  // Target models, sampled mid-cycle
  always @(negedge clk) begin
    logic [71:0] s;
    logic [31:0] rd;
    int          c;
    for (int t = 0; t < 4; t++) begin
      if (tgt_rsp_valid[t] && tgt_rsp_ready[t]) begin
        void'(trsp_q[t].pop_front());
        void'(due_q[t].pop_front());
      end
      if (tgt_req_valid[t] && tgt_req_ready[t]) begin
        c = int'(tgt_req_addr[t][4]);
        assert (sent_q[c].size() > 0) else begin
          other_errs++;
          $display("Target %0d got a request that no cluster issued", t);
        end
        if (sent_q[c].size() > 0) begin
          s = sent_q[c].pop_front();
          compare_value("target index of tgt_req_valid", 32'(t), 32'(s[71:69]));
          compare_value($sformatf("tgt_req_addr[%0d]", t), tgt_req_addr[t], s[68:37]);
          compare_value($sformatf("tgt_req_write[%0d]", t), 32'(tgt_req_write[t]), 32'(s[36]));
          compare_value($sformatf("tgt_req_wdata[%0d]", t), tgt_req_wdata[t], s[35:4]);
          compare_value($sformatf("tgt_req_id[%0d]", t), 32'(tgt_req_id[t]),
                        32'({c[0], s[3:0]}));
        end
        if (tgt_req_write[t]) begin
          tgt_mem[tgt_req_addr[t]] = tgt_req_wdata[t];
          rd = '0;
        end else begin
          rd = tgt_mem.exists(tgt_req_addr[t]) ? tgt_mem[tgt_req_addr[t]]
                                                : fill_word(tgt_req_addr[t]);
        end
        trsp_q[t].push_back({rd, 1'b0, tgt_req_id[t]});
        due_q[t].push_back(cyc + 1 + int'($unsigned($random(seed)) % 4));
      end
    end
  end

  always @(posedge clk) begin
    #2;
    cyc++;
    for (int t = 0; t < 4; t++) begin
      tgt_req_ready[t] = always_rdy || $random(seed) % 4 != 0;
      tgt_rsp_valid[t] = 1'b0;
      if (trsp_q[t].size() > 0) begin
        tgt_rsp_valid[t] = due_q[t][0] <= cyc;  // Held until taken
        {tgt_rsp_rdata[t], tgt_rsp_err[t], tgt_rsp_id[t]} = trsp_q[t][0];
      end
    end
    for (int c = 0; c < 2; c++) cl_rsp_ready[c] = !rsp_rand || $random(seed) % 2 == 0;
  end

  // Request latency and scoreboard
  always @(negedge clk) begin
    logic [36:0] e;
    int          t;
    for (int k = 0; k < 4; k++) begin
      if (lat_pend[k]) begin
        assert (tgt_req_valid[k]) else begin
          other_errs++;
          $display("Target %0d request not valid one cycle after acceptance", k);
        end
        compare_value($sformatf("tgt_req_id[%0d]", k), 32'(tgt_req_id[k]), 32'(lat_id[k]));
      end
    end
    lat_pend = '0;
    for (int c = 0; c < 2; c++) begin
      if (cl_req_valid[c] && cl_req_ready[c]) begin
        t = target_of(cl_req_addr[c]);
        if (t >= 0 && t < 4 && (!tgt_req_valid[t] || tgt_req_ready[t])) begin
          lat_pend[t] = 1'b1;
          lat_id[t]   = {c[0], cl_req_id[c]};
        end
      end
      if (cl_rsp_valid[c] && cl_rsp_ready[c]) begin
        assert (exp_q[c].size() > 0) else begin
          other_errs++;
          $display("Cluster %0d got a response with nothing outstanding", c);
        end
        if (exp_q[c].size() > 0) begin
          e = exp_q[c].pop_front();
          compare_value($sformatf("cl_rsp_rdata[%0d]", c), cl_rsp_rdata[c], e[36:5]);
          compare_value($sformatf("cl_rsp_err[%0d]", c), 32'(cl_rsp_err[c]), 32'(e[4]));
          compare_value($sformatf("cl_rsp_id[%0d]", c), 32'(cl_rsp_id[c]), 32'(e[3:0]));
        end
      end
    end
  end

  initial begin
    int waited;
    cl_req_valid  = '0;
    cl_req_addr   = '0;
    cl_req_write  = '0;
    cl_req_wdata  = '0;
    cl_req_id     = '0;
    cl_rsp_ready  = '0;
    tgt_req_ready = '0;
    tgt_rsp_valid = '0;
    tgt_rsp_rdata = '0;
    tgt_rsp_err   = '0;
    tgt_rsp_id    = '0;
    lat_pend      = '0;
    always_rdy    = 1'b1;
    rsp_rand      = 1'b0;
    waited = 0;
    while (!rst_n && waited < 100) begin
      @(posedge clk);
      waited++;
    end
    assert (rst_n) else begin
      other_errs++;
      $display("Reset was never released");
    end
    @(posedge clk);
    #2;
    fork
      run_cluster(0, 0, 40);
      run_cluster(1, 0, 40);
    join
    drain_responses();
    always_rdy = 1'b0;  // Back-pressure from here on
    rsp_rand   = 1'b1;
    fork
      run_cluster(0, 1, 60);
      run_cluster(1, 1, 60);
    join
    drain_responses();
    fork
      run_cluster(0, 2, 100);
      run_cluster(1, 2, 100);
    join
    drain_responses();
    $display("Errors: %0d wrong values, %0d other failures", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_PERIOD  = 20;  // 40 ns clock
  localparam int RESET_CYCLES = 16;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2 rst_n = 1'b1;  // Released just after the edge
  end

endmodule

`default_nettype wire
